//--- decode_dispatch.f
+incdir+verification
hw/decode_pkg.sv
hw/inst_decoder.sv
hw/operand_resolver.sv
hw/dispatch_stage.sv
hw/decode_dispatch.sv
verification/decode_dispatch_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the decode_dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f decode_dispatch.f --top-module decode_dispatch_tb -o decode_dispatch_sim

./obj_dir/decode_dispatch_sim > sim.log 2>&1 || true
cat sim.log

grep -q "Simulation PASSED" sim.log
echo "run finished with a clean result"

//--- verification/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// stimulus: name inst pc rf1 rf2 dep1 dep2 q1 q2 tail ctl rnd
// expected: ok npc idx vld robk rob_val raddr rd op off r1 r1d r2 r2d chk

task automatic add_row(input string name, input logic [31:0] inst, pc, rf1, rf2,
                       input logic [4:0] dep1, dep2, input logic [32:0] q1, q2,
                       input logic [3:0] tail, input logic [4:0] ctl, input logic [1:0] rnd,
                       input logic ok, input logic [31:0] npc, input logic [9:0] idx,
                       input logic [2:0] vld, robk, input logic [31:0] rob_val, raddr,
                       input logic [4:0] rd, op,
                       input logic [11:0] off, input logic [31:0] r1, input logic [4:0] r1d,
                       input logic [31:0] r2, input logic [4:0] r2d, input logic [1:0] chk);
    row_t r;
    r = '{inst, pc, rf1, rf2, dep1, dep2, q1, q2, tail, ctl, rnd,
          ok, npc, idx, vld, robk, rob_val, raddr, rd, op, off, r1, r1d, r2, r2d, chk};
    names.push_back(name);
    rows.push_back(r);
endtask

task automatic load_vectors();
    add_row("add", 'h002081B3, 'h000, 'h11, 'h22, 0, 0, 0, 0, 1, 'h08, 0,
            1, 'h004, {5'd1, 5'd2}, 'b110, 0, 0, 'h000, 3, 'h00, 0, 'h11, 0, 'h22, 0, 'b11);
    add_row("sub", 'h407302B3, 'h004, 'h50, 'h8, 0, 0, 0, 0, 2, 'h08, 0,
            1, 'h008, {5'd6, 5'd7}, 'b110, 0, 0, 'h004, 5, 'h08, 0, 'h50, 0, 'h8, 0, 'b11);
    add_row("addi", 'hFFD08213, 'h008, 'h7, 0, 0, 0, 0, 0, 3, 'h08, 'b10,
            1, 'h00C, {5'd1, 5'd0}, 'b110, 0, 0, 'h008, 4, 'h00, 0,
            'h7, 0, 'hFFFFFFFD, 0, 'b11);
    add_row("srai", 'h40515313, 'h00C, 'h80, 0, 0, 0, 0, 0, 4, 'h08, 'b10,
            1, 'h010, {5'd2, 5'd0}, 'b110, 0, 0, 'h00C, 6, 'h0D, 0, 'h80, 0, 'h5, 0, 'b11);
    add_row("lw", 'h0080A383, 'h010, 'h1000, 0, 0, 0, 0, 0, 5, 'h08, 'b10,
            1, 'h014, {5'd1, 5'd0}, 'b101, 0, 0, 'h010, 7, 'h02, 'h008,
            'h1000, 0, 0, 0, 'b01);
    add_row("sw", 'h0020A623, 'h014, 'h1000, 'hABCD, 0, 0, 0, 0, 6, 'h08, 0,
            1, 'h018, {5'd1, 5'd2}, 'b101, 5, 0, 'h014, 0, 'h0A, 'h00C,
            'h1000, 0, 'hABCD, 0, 'b11);
    add_row("jal", 'h010000EF, 'h100, 0, 0, 0, 0, 0, 0, 7, 'h08, 'b11,
            1, 'h110, {5'd0, 5'd0}, 'b100, 4, 'h104, 'h100, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row("jalr", 'h004280E7, 'h110, 'h2000, 0, 0, 0, 0, 0, 8, 'h08, 'b10,
            1, 'h2004, {5'd5, 5'd0}, 'b100, 4, 'h114, 'h110, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row("lui", 'h12345437, 'h114, 0, 0, 0, 0, 0, 0, 8, 'h08, 'b11,
            1, 'h118, {5'd0, 5'd0}, 'b100, 4, 'h12345000, 'h114, 8, 0, 0,
            0, 0, 0, 0, 0);
    add_row("auipc", 'h00001497, 'h200, 0, 0, 0, 0, 0, 0, 8, 'h08, 'b11,
            1, 'h204, {5'd0, 5'd0}, 'b100, 4, 'h1200, 'h200, 9, 0, 0, 0, 0, 0, 0, 0);
    add_row("beq", 'hFE208CE3, 'h300, 'h3, 'h3, 0, 0, 0, 0, 9, 'h08, 0,
            1, 'h304, {5'd1, 5'd2}, 'b110, 2, 'h2F8, 'h300, 0, 'h10, 0, 'h3, 0, 'h3, 0, 'b11);
    add_row("fwd_ready", 'h002081B3, 'h304, 0, 'h22, 'h13, 0, 'h100000055, 0, 'hA, 'h08, 0,
            1, 'h308, {5'd1, 5'd2}, 'b110, 0, 0, 'h304, 3, 'h00, 0, 'h55, 0, 'h22, 0, 'b11);
    add_row("dep_wait", 'h002081B3, 'h308, 'h11, 0, 0, 'h19, 0, 0, 'hB, 'h08, 0,
            1, 'h30C, {5'd1, 5'd2}, 'b110, 0, 0, 'h308, 3, 'h00, 0, 'h11, 0, 0, 'h19, 'b11);
    add_row("jalr_dep", 'h004280E7, 'h30C, 0, 0, 'h14, 0, 0, 0, 'hC, 'h08, 'b10,
            0, 'h004, {5'd5, 5'd0}, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row("rs_full", 'h002081B3, 'h30C, 1, 2, 0, 0, 0, 0, 'hC, 'h0A, 0,
            0, 'h310, {5'd1, 5'd2}, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row("lsb_full_lw", 'h0080A383, 'h30C, 1, 0, 0, 0, 0, 0, 'hC, 'h0C, 'b10,
            0, 'h310, {5'd1, 5'd0}, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row("rob_full", 'h0020A623, 'h30C, 1, 2, 0, 0, 0, 0, 'hC, 'h09, 0,
            0, 'h310, {5'd1, 5'd2}, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row("lsb_full_add", 'h002081B3, 'h30C, 1, 2, 0, 0, 0, 0, 'hC, 'h0C, 0,
            1, 'h310, {5'd1, 5'd2}, 'b110, 0, 0, 'h30C, 3, 'h00, 0, 1, 0, 2, 0, 'b11);
    add_row("dup_addr", 'h002081B3, 'h30C, 1, 2, 0, 0, 0, 0, 'hC, 'h08, 0,
            0, 'h310, {5'd1, 5'd2}, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row("add_pre", 'h002081B3, 'h310, 4, 5, 0, 0, 0, 0, 'hD, 'h08, 0,
            1, 'h314, {5'd1, 5'd2}, 'b110, 0, 0, 'h310, 3, 'h00, 0, 4, 0, 5, 0, 'b11);
    // rdy low, registers keep the add_pre entries
    add_row("pause", 'h407302B3, 'h314, 9, 1, 0, 0, 0, 0, 'hD, 'h00, 0,
            1, 'h318, {5'd6, 5'd7}, 'b110, 0, 0, 'h310, 3, 'h00, 0, 4, 0, 5, 0, 'b11);
    add_row("resume", 'h407302B3, 'h314, 9, 1, 0, 0, 0, 0, 'hE, 'h08, 0,
            1, 'h318, {5'd6, 5'd7}, 'b110, 0, 0, 'h314, 5, 'h08, 0, 9, 0, 1, 0, 'b11);
    add_row("clear", 'h407302B3, 'h314, 9, 1, 0, 0, 0, 0, 'hE, 'h18, 0,
            0, 'h318, {5'd6, 5'd7}, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row("redispatch", 'h407302B3, 'h314, 9, 1, 0, 0, 0, 0, 'hF, 'h08, 0,
            1, 'h318, {5'd6, 5'd7}, 'b110, 0, 0, 'h314, 5, 'h08, 0, 9, 0, 1, 0, 'b11);
endtask

`endif

//--- verification/decode_dispatch_tb.sv
`timescale 1ns/1ps

module decode_dispatch_tb;
    import decode_pkg::*;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] rf1;
        logic [31:0] rf2;
        logic [4:0]  dep1;    // {has_dep, tag}
        logic [4:0]  dep2;
        logic [32:0] q1;      // {ready, value}
        logic [32:0] q2;
        logic [3:0]  tail;
        logic [4:0]  ctl;     // {clear, rdy, lsb_full, rs_full, rob_full}
        logic [1:0]  rnd;     // random rf value for unused sources
        logic        ok;
        logic [31:0] npc;
        logic [9:0]  idx;     // {rf_idx1, rf_idx2}
        logic [2:0]  vld;     // {rob, rs, lsb}
        logic [2:0]  robk;    // {ready, rtype}
        logic [31:0] rob_val;
        logic [31:0] raddr;
        logic [4:0]  rd;
        logic [4:0]  op;
        logic [11:0] off;
        logic [31:0] r1;
        logic [4:0]  r1d;
        logic [31:0] r2;
        logic [4:0]  r2d;
        logic [1:0]  chk;     // {check r2, check r1}
    } row_t;

    logic                 clk_in;
    logic                 arst_n;
    logic                 rdy_in;
    logic                 rob_clear;
    fetch_pkt_t           fetch;
    logic                 f_ok;
    logic [XLEN-1:0]      f_next_pc;
    logic [REG_IDX_W-1:0] rf_idx1;
    logic [REG_IDX_W-1:0] rf_idx2;
    rf_read_t             rf_read1;
    rf_read_t             rf_read2;
    rob_query_t           rob_q1;
    rob_query_t           rob_q2;
    logic [ROB_IDX_W-1:0] rob_tail;
    logic                 rob_full;
    logic                 rs_full;
    logic                 lsb_full;
    rob_entry_t           rob_entry;
    issue_entry_t         rs_issue;
    rs_op_t               rs_op;
    issue_entry_t         lsb_issue;
    lsb_op_t              lsb_op;
    logic [11:0]          lsb_offset;
    logic [REG_IDX_W-1:0] rf_set_idx;
    logic [ROB_IDX_W-1:0] rf_set_dep;

    row_t        rows[$];
    string       names[$];
    int unsigned seed = 92151;
    int          errors = 0;
    int          failed_tests = 0;
    bit          row_bad;

    decode_dispatch decode_dispatch_inst (.*);

    always #4 clk_in = ~clk_in;

    `include "decode_vectors.svh"

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic check_val(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s %s expected %h actual %h", test, what, exp, act);
            errors++;
            row_bad = 1'b1;
        end
    endtask

    task automatic drive_row(input row_t r);
        fetch     = '{valid: 1'b1, addr: r.pc, data: r.inst};
        rf_read1  = '{val: r.rnd[0] ? lcg_next() : r.rf1, has_dep: r.dep1[4], dep: r.dep1[3:0]};
        rf_read2  = '{val: r.rnd[1] ? lcg_next() : r.rf2, has_dep: r.dep2[4], dep: r.dep2[3:0]};
        rob_q1    = '{ready: r.q1[32], value: r.q1[31:0]};
        rob_q2    = '{ready: r.q2[32], value: r.q2[31:0]};
        rob_tail  = r.tail;
        rob_full  = r.ctl[0];
        rs_full   = r.ctl[1];
        lsb_full  = r.ctl[2];
        rdy_in    = r.ctl[3];
        rob_clear = r.ctl[4];
    endtask

    task automatic check_operand(input string test, input string what,
                                 input operand_t op, input logic [31:0] val,
                                 input logic [4:0] d);
        check_val(test, {what, " value"}, val, op.value);
        check_val(test, {what, " has_dep"}, 32'(d[4]), 32'(op.has_dep));
        if (d[4]) begin
            check_val(test, {what, " dep"}, 32'(d[3:0]), 32'(op.dep));
        end
    endtask

    task automatic check_registered(input string test, input row_t r);
        issue_entry_t iss;
        iss = r.vld[1] ? rs_issue : lsb_issue;
        check_val(test, "rob valid", 32'(r.vld[2]), 32'(rob_entry.valid));
        check_val(test, "rs valid", 32'(r.vld[1]), 32'(rs_issue.valid));
        check_val(test, "lsb valid", 32'(r.vld[0]), 32'(lsb_issue.valid));
        check_val(test, "rf_set_idx", 32'(r.rd), 32'(rf_set_idx));
        check_val(test, "rf_set_dep", 32'(r.tail), 32'(rf_set_dep));
        if (r.vld[2]) begin
            check_val(test, "rob kind", 32'(r.robk), 32'({rob_entry.ready, rob_entry.rtype}));
            check_val(test, "rob value", r.rob_val, rob_entry.value);
            check_val(test, "rob rd", 32'(r.rd), 32'(rob_entry.rd));
            check_val(test, "rob addr", r.raddr, rob_entry.addr);
        end
        if (r.vld[1] || r.vld[0]) begin
            check_val(test, "rob_idx", 32'(r.tail), 32'(iss.rob_idx));
            if (r.vld[1]) begin
                check_val(test, "rs_op", 32'(r.op), 32'(rs_op));
            end else begin
                check_val(test, "lsb_op", 32'(r.op[3:0]), 32'(lsb_op));
                check_val(test, "lsb_offset", 32'(r.off), 32'(lsb_offset));
            end
            if (r.chk[0]) begin
                check_operand(test, "r1", iss.r1, r.r1, r.r1d);
            end
            if (r.chk[1]) begin
                check_operand(test, "r2", iss.r2, r.r2, r.r2d);
            end
        end
    endtask

    initial begin
        clk_in    = 1'b0;
        arst_n    = 1'b0;
        rdy_in    = 1'b1;
        rob_clear = 1'b0;
        fetch     = '0;
        rf_read1  = '0;
        rf_read2  = '0;
        rob_q1    = '0;
        rob_q2    = '0;
        rob_tail  = '0;
        rob_full  = 1'b0;
        rs_full   = 1'b0;
        lsb_full  = 1'b0;
        load_vectors();
        repeat (10) @(posedge clk_in);
        #1 arst_n = 1'b1;

        foreach (rows[i]) begin
            row_bad = 1'b0;
            drive_row(rows[i]);
            #3; // combinational answer settles well before the edge
            check_val(names[i], "f_ok", 32'(rows[i].ok), 32'(f_ok));
            check_val(names[i], "f_next_pc", rows[i].npc, f_next_pc);
            check_val(names[i], "rf_idx1", 32'(rows[i].idx[9:5]), 32'(rf_idx1));
            check_val(names[i], "rf_idx2", 32'(rows[i].idx[4:0]), 32'(rf_idx2));
            @(posedge clk_in);
            #1;
            check_registered(names[i], rows[i]);
            if (row_bad) begin
                failed_tests++;
                $display("test %s: mismatch", names[i]);
            end else begin
                $display("test %s: ok", names[i]);
            end
        end

        $display("tests %0d, failed %0d, errors %0d", rows.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #1;
        #((rows.size() * 4 + 10) * 8);
        $display("timeout: the test loop did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- hw/decode_dispatch.sv
`timescale 1ns/1ps

module decode_dispatch
    import decode_pkg::*;
(
    input  logic                 clk_in,
    input  logic                 arst_n,
    input  logic                 rdy_in,
    input  logic                 rob_clear,
    input  fetch_pkt_t           fetch,
    output logic                 f_ok,
    output logic [XLEN-1:0]      f_next_pc,
    output logic [REG_IDX_W-1:0] rf_idx1,
    output logic [REG_IDX_W-1:0] rf_idx2,
    input  rf_read_t             rf_read1,
    input  rf_read_t             rf_read2,
    input  rob_query_t           rob_q1,
    input  rob_query_t           rob_q2,
    input  logic [ROB_IDX_W-1:0] rob_tail,
    input  logic                 rob_full,
    input  logic                 rs_full,
    input  logic                 lsb_full,
    output rob_entry_t           rob_entry,
    output issue_entry_t         rs_issue,
    output rs_op_t               rs_op,
    output issue_entry_t         lsb_issue,
    output lsb_op_t              lsb_op,
    output logic [11:0]          lsb_offset,
    output logic [REG_IDX_W-1:0] rf_set_idx,
    output logic [ROB_IDX_W-1:0] rf_set_dep
);

    decoded_t     dec;
    operand_t     op1;
    operand_t     op2;
    issue_entry_t rs_reg;
    issue_entry_t lsb_reg;

    assign rf_idx1 = dec.rs1;
    assign rf_idx2 = dec.rs2;

    inst_decoder inst_decoder_inst (
        .inst (fetch.data),
        .pc   (fetch.addr),
        .dec  (dec)
    );

    operand_resolver operand_resolver_inst (
        .rf_read1 (rf_read1),
        .rf_read2 (rf_read2),
        .rob_q1   (rob_q1),
        .rob_q2   (rob_q2),
        .use_rs1  (dec.use_rs1),
        .use_rs2  (dec.use_rs2),
        .op1      (op1),
        .op2      (op2)
    );

    dispatch_stage dispatch_stage_inst (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .rob_clear  (rob_clear),
        .rdy_in     (rdy_in),
        .fetch      (fetch),
        .dec        (dec),
        .op1        (op1),
        .op2        (op2),
        .rob_full   (rob_full),
        .rs_full    (rs_full),
        .lsb_full   (lsb_full),
        .f_ok       (f_ok),
        .f_next_pc  (f_next_pc),
        .rob_entry  (rob_entry),
        .rs_issue   (rs_reg),
        .lsb_issue  (lsb_reg),
        .rs_op      (rs_op),
        .lsb_op     (lsb_op),
        .lsb_offset (lsb_offset),
        .rf_set_idx (rf_set_idx)
    );

    // the entry sits at the current rob tail
    assign rs_issue   = '{valid: rs_reg.valid, rob_idx: rob_tail, r1: rs_reg.r1, r2: rs_reg.r2};
    assign lsb_issue  = '{valid: lsb_reg.valid, rob_idx: rob_tail, r1: lsb_reg.r1,
                          r2: lsb_reg.r2};
    assign rf_set_dep = rob_tail;

endmodule

//--- hw/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage
    import decode_pkg::*;
(
    input  logic                 clk_in,
    input  logic                 arst_n,
    input  logic                 rob_clear,
    input  logic                 rdy_in,
    input  fetch_pkt_t           fetch,
    input  decoded_t             dec,
    input  operand_t             op1,
    input  operand_t             op2,
    input  logic                 rob_full,
    input  logic                 rs_full,
    input  logic                 lsb_full,
    output logic                 f_ok,
    output logic [XLEN-1:0]      f_next_pc,
    output rob_entry_t           rob_entry,
    output issue_entry_t         rs_issue,
    output issue_entry_t         lsb_issue,
    output rs_op_t               rs_op,
    output lsb_op_t              lsb_op,
    output logic [11:0]          lsb_offset,
    output logic [REG_IDX_W-1:0] rf_set_idx
);

    logic [XLEN-1:0] last_addr;
    logic            new_fetch;
    logic            can_issue;
    rob_type_e       rtype;
    operand_t        r2;

    assign new_fetch = fetch.valid && (fetch.addr != last_addr);
    assign can_issue = !rob_full &&
                       (!dec.need_rs || !rs_full) &&
                       (!dec.need_lsb || !lsb_full) &&
                       (dec.opcode != JALR || !op1.has_dep); // jalr needs its base now
    assign f_ok = new_fetch && can_issue;

    always_comb begin
        unique case (dec.opcode)
            JALR:    f_next_pc = op1.value + dec.imm_r2;
            JAL:     f_next_pc = fetch.addr + dec.imm_r2;
            default: f_next_pc = fetch.addr + INST_BYTES;
        endcase
    end

    always_comb begin
        unique case (dec.opcode)
            STORE:   rtype = ROB_ST;
            BRANCH:  rtype = ROB_BR;
            default: rtype = ROB_RG;
        endcase
    end

    always_comb begin
        r2 = op2;
        if (dec.use_imm_r2) begin
            r2.value = dec.imm_r2;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            last_addr  <= RESET_ADDR;
            rob_entry  <= '0;
            rs_issue   <= '0;
            lsb_issue  <= '0;
            rs_op      <= '0;
            lsb_op     <= '0;
            lsb_offset <= '0;
            rf_set_idx <= '0;
        end else if (rob_clear) begin
            last_addr  <= RESET_ADDR; // same address may dispatch again
            rob_entry  <= '0;
            rs_issue   <= '0;
            lsb_issue  <= '0;
            rs_op      <= '0;
            lsb_op     <= '0;
            lsb_offset <= '0;
            rf_set_idx <= '0;
        end else if (rdy_in) begin
            if (f_ok) begin
                last_addr <= fetch.addr;

                rob_entry.valid <= 1'b1;
                rob_entry.ready <= dec.rob_ready;
                rob_entry.rtype <= rtype;
                rob_entry.value <= dec.rob_value;
                rob_entry.rd    <= dec.use_rd ? dec.rd : '0;
                rob_entry.addr  <= fetch.addr;

                rs_issue  <= '{valid: dec.need_rs, rob_idx: '0, r1: op1, r2: r2};
                lsb_issue <= '{valid: dec.need_lsb, rob_idx: '0, r1: op1, r2: r2};

                rs_op      <= dec.rs_op;
                lsb_op     <= dec.lsb_op;
                lsb_offset <= dec.lsb_offset;
                rf_set_idx <= dec.use_rd ? dec.rd : '0;
            end else begin
                rob_entry.valid <= 1'b0;
                rs_issue.valid  <= 1'b0;
                lsb_issue.valid <= 1'b0;
                rf_set_idx      <= '0;
            end
        end
    end

    rs_lsb_exclusive: assert property (@(posedge clk_in) disable iff (!arst_n)
        !(rs_issue.valid && lsb_issue.valid));

    // paused cycle must not produce new work
    no_valid_after_pause: assert property (@(posedge clk_in) disable iff (!arst_n)
        !rdy_in |=> !($rose(rob_entry.valid) || $rose(rs_issue.valid) ||
                      $rose(lsb_issue.valid)));

endmodule

//--- hw/operand_resolver.sv
`timescale 1ns/1ps

module operand_resolver
    import decode_pkg::*;
(
    input  rf_read_t   rf_read1,
    input  rf_read_t   rf_read2,
    input  rob_query_t rob_q1,
    input  rob_query_t rob_q2,
    input  logic       use_rs1,
    input  logic       use_rs2,
    output operand_t   op1,
    output operand_t   op2
);

    // rf value, else forward from rob, else wait on the tag
    function automatic operand_t resolve(input rf_read_t rf, input rob_query_t q,
                                         input logic used);
        operand_t op;
        op.value   = !rf.has_dep ? rf.val : (q.ready ? q.value : '0);
        op.has_dep = used && rf.has_dep && !q.ready;
        op.dep     = rf.dep;
        return op;
    endfunction

    assign op1 = resolve(rf_read1, rob_q1, use_rs1);
    assign op2 = resolve(rf_read2, rob_q2, use_rs2);

    always_comb begin
        // unused sources read x0, which never waits on the rob
        assert (use_rs1 || !rf_read1.has_dep) else $error("dependency on unused rs1");
        assert (use_rs2 || !rf_read2.has_dep) else $error("dependency on unused rs2");
    end

endmodule

//--- hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import decode_pkg::*;
(
    input  logic [XLEN-1:0] inst,
    input  logic [XLEN-1:0] pc,
    output decoded_t        dec
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_sh;
    logic [XLEN-1:0] next_addr;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    assign imm_i  = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s  = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u  = {inst[31:12], 12'b0};
    assign imm_j  = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_sh = {{(XLEN-5){1'b0}}, inst[24:20]}; // shamt, unsigned

    assign next_addr = pc + INST_BYTES;

    always_comb begin
        dec = '0;
        dec.opcode = opcode;
        dec.rd     = inst[11:7];

        dec.rs_op.is_branch = (opcode == BRANCH);
        dec.rs_op.funct3    = funct3;
        // srai shares funct3 with srli, addi etc. must ignore bit 30
        dec.rs_op.alt = (opcode == ARITH_R && inst[30]) ||
                        (opcode == ARITH_I && funct3 == 3'b101 && inst[30]);

        dec.lsb_op.is_store = (opcode == STORE);
        dec.lsb_op.funct3   = funct3;
        dec.lsb_offset      = (opcode == STORE) ? imm_s[11:0] : imm_i[11:0];

        unique case (opcode)
            ARITH_R: begin
                dec.use_rs1 = 1'b1;
                dec.use_rs2 = 1'b1;
                dec.use_rd  = 1'b1;
                dec.need_rs = 1'b1;
            end
            ARITH_I: begin
                dec.use_rs1    = 1'b1;
                dec.use_rd     = 1'b1;
                dec.need_rs    = 1'b1;
                dec.use_imm_r2 = 1'b1;
                dec.imm_r2     = (funct3 == 3'b001 || funct3 == 3'b101) ? imm_sh : imm_i;
            end
            LOAD: begin
                dec.use_rs1  = 1'b1;
                dec.use_rd   = 1'b1;
                dec.need_lsb = 1'b1;
            end
            STORE: begin
                dec.use_rs1   = 1'b1;
                dec.use_rs2   = 1'b1;
                dec.need_lsb  = 1'b1;
                dec.rob_ready = 1'b1;
            end
            BRANCH: begin
                dec.use_rs1   = 1'b1;
                dec.use_rs2   = 1'b1;
                dec.need_rs   = 1'b1;
                dec.rob_value = pc + imm_b; // taken target
            end
            JAL: begin
                dec.use_rd    = 1'b1;
                dec.rob_ready = 1'b1;
                dec.rob_value = next_addr;
                dec.imm_r2    = imm_j;
            end
            JALR: begin
                dec.use_rs1   = 1'b1;
                dec.use_rd    = 1'b1;
                dec.rob_ready = 1'b1;
                dec.rob_value = next_addr;
                dec.imm_r2    = imm_i;
            end
            AUIPC: begin
                dec.use_rd    = 1'b1;
                dec.rob_ready = 1'b1;
                dec.rob_value = pc + imm_u;
            end
            LUI: begin
                dec.use_rd    = 1'b1;
                dec.rob_ready = 1'b1;
                dec.rob_value = imm_u;
            end
            default: ; // unknown opcode goes out as a bare ROB entry
        endcase

        // unused source fields are immediate bits, read x0 instead
        dec.rs1 = dec.use_rs1 ? inst[19:15] : '0;
        dec.rs2 = dec.use_rs2 ? inst[24:20] : '0;
    end

endmodule

//--- hw/decode_pkg.sv
package decode_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int ROB_IDX_W = 4;

    localparam logic [XLEN-1:0] INST_BYTES = 32'd4;
    localparam logic [XLEN-1:0] RESET_ADDR = '1; // never matches a real fetch

    typedef enum logic [6:0] {
        ARITH_R = 7'b0110011,
        ARITH_I = 7'b0010011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        BRANCH  = 7'b1100011,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        AUIPC   = 7'b0010111,
        LUI     = 7'b0110111
    } opcode_e;

    typedef enum logic [1:0] {
        ROB_RG,
        ROB_ST,
        ROB_BR
    } rob_type_e;

    typedef struct packed {
        logic       is_branch;
        logic       alt;       // funct7[5], sub / sra
        logic [2:0] funct3;
    } rs_op_t;

    typedef struct packed {
        logic       is_store;
        logic [2:0] funct3;
    } lsb_op_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } fetch_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0]      val;
        logic                 has_dep;
        logic [ROB_IDX_W-1:0] dep;
    } rf_read_t;

    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] value;
    } rob_query_t;

    typedef struct packed {
        logic [XLEN-1:0]      value;
        logic                 has_dep;
        logic [ROB_IDX_W-1:0] dep;
    } operand_t;

    typedef struct packed {
        opcode_e              opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic                 use_rs1;
        logic                 use_rs2;
        logic                 use_rd;
        logic                 need_rs;
        logic                 need_lsb;
        rs_op_t               rs_op;
        lsb_op_t              lsb_op;
        logic [11:0]          lsb_offset;
        logic [XLEN-1:0]      imm_r2;     // also carries the jump offset
        logic                 use_imm_r2;
        logic                 rob_ready;
        logic [XLEN-1:0]      rob_value;
    } decoded_t;

    typedef struct packed {
        logic                 valid;
        logic                 ready;
        rob_type_e            rtype;
        logic [XLEN-1:0]      value;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      addr;
    } rob_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_IDX_W-1:0] rob_idx;
        operand_t             r1;
        operand_t             r2;
    } issue_entry_t;

endpackage
